// ==== hdl/io_pkg.sv ====
package io_pkg;

  // bus and pad widths
  localparam int GPIO_W = 16;
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int STRB_W = 4;

  // upper address bits of the io page
  localparam logic [23:0] IO_PAGE = 24'h030000;

  // gpio control registers
  localparam logic [7:0] OFS_GPIO_DAT  = 8'h00;
  localparam logic [7:0] OFS_GPIO_OEB  = 8'h04;
  localparam logic [7:0] OFS_GPIO_PU   = 8'h08;
  localparam logic [7:0] OFS_GPIO_PD   = 8'h0c;

  // housekeeping words, read only
  localparam logic [7:0] OFS_HK_CFG    = 8'h80;
  localparam logic [7:0] OFS_HK_ENA    = 8'h84;
  localparam logic [7:0] OFS_HK_PLL    = 8'h88;
  localparam logic [7:0] OFS_HK_MFGR   = 8'h8c;
  localparam logic [7:0] OFS_HK_PROD   = 8'h90;
  localparam logic [7:0] OFS_HK_MASK   = 8'h94;
  localparam logic [7:0] OFS_CLK_SEL   = 8'h98;

  // pad routing and irq source selection
  localparam logic [7:0] OFS_XTAL_DEST = 8'ha0;
  localparam logic [7:0] OFS_PLL_DEST  = 8'ha4;
  localparam logic [7:0] OFS_TRAP_DEST = 8'ha8;
  localparam logic [7:0] OFS_IRQ7_SRC  = 8'hb0;
  localparam logic [7:0] OFS_IRQ8_SRC  = 8'hb4;

  // code 0 leaves the pins as plain gpio
  localparam int SEL_W = 2;

  // first pin of each three-pin group
  localparam int XTAL_PIN_LO = 5;
  localparam int PLL_PIN_LO  = 8;
  localparam int TRAP_PIN_LO = 11;
  localparam int IRQ7_PIN_LO = 0;
  localparam int IRQ8_PIN_LO = 3;

  localparam int HK_CFG_W  = 8;
  localparam int HK_TRIM_W = 4;
  localparam int HK_MFGR_W = 12;
  localparam int HK_PROD_W = 8;
  localparam int HK_MASK_W = 4;

  localparam logic [GPIO_W-1:0] OEB_RESET = {GPIO_W{1'b1}};

  // bus slave controller states
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ACCESS = 2'd1;
  localparam logic [1:0] ST_ACK    = 2'd2;

endpackage

// ==== hdl/io_bus_slave.sv ====
`timescale 1ns/1ps

module io_bus_slave (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        bus_req_i,
  input  logic [io_pkg::ADDR_W-1:0]   bus_addr_i,
  input  logic [io_pkg::DATA_W-1:0]   bus_wdata_i,
  input  logic [io_pkg::STRB_W-1:0]   bus_wstrb_i,
  output logic                        bus_ack_o,
  output logic [io_pkg::DATA_W-1:0]   bus_rdata_o,
  output logic                        acc_o,
  output logic [7:0]                  ofs_o,
  output logic [io_pkg::DATA_W-1:0]   wdata_o,
  output logic [io_pkg::STRB_W-1:0]   wstrb_o,
  input  logic [io_pkg::DATA_W-1:0]   rdata_i
);

  import io_pkg::*;

  logic [1:0]        state_q;
  logic              ack_q;
  logic              page_hit_q;
  logic [7:0]        ofs_q;
  logic [DATA_W-1:0] wdata_q;
  logic [STRB_W-1:0] wstrb_q;
  logic [DATA_W-1:0] rdata_q;
  logic              start;
  logic              ack_set;

  // new request seen while idle, ack is always low here
  assign start   = (state_q == ST_IDLE) && bus_req_i;
  // first edge in the ack state, read word from the registers is ready
  assign ack_set = (state_q == ST_ACK) && !ack_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      ack_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (bus_req_i) begin
            state_q <= ST_ACCESS;
          end
        end
        ST_ACCESS: begin
          state_q <= ST_ACK;
        end
        ST_ACK: begin
          if (!ack_q) begin
            ack_q <= 1'b1;
          end else if (!bus_req_i) begin
            // master let go, close the handshake
            ack_q   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      ofs_q      <= bus_addr_i[7:0];
      wdata_q    <= bus_wdata_i;
      wstrb_q    <= bus_wstrb_i;
      page_hit_q <= (bus_addr_i[ADDR_W-1:8] == IO_PAGE);
    end
    if (ack_set) begin
      // foreign page reads back as zero
      rdata_q <= page_hit_q ? rdata_i : '0;
    end
  end

  assign acc_o       = (state_q == ST_ACCESS) && page_hit_q;
  assign ofs_o       = ofs_q;
  assign wdata_o     = wdata_q;
  assign wstrb_o     = wstrb_q;
  assign bus_ack_o   = ack_q;
  assign bus_rdata_o = rdata_q;

  // ack only rises into a request that is still held
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(bus_ack_o) |-> bus_req_i);

  // exactly one register access per bus transfer
  acc_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_o |=> !acc_o);

endmodule

// ==== hdl/io_ctrl_regs.sv ====
`timescale 1ns/1ps

module io_ctrl_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           acc_i,
  input  logic [7:0]                     ofs_i,
  input  logic [io_pkg::DATA_W-1:0]      wdata_i,
  input  logic [io_pkg::STRB_W-1:0]      wstrb_i,
  input  logic [io_pkg::GPIO_W-1:0]      gpio_in_i,
  input  logic [io_pkg::GPIO_W-1:0]      gpio_out_i,
  input  logic [io_pkg::HK_CFG_W-1:0]    hk_config_i,
  input  logic                           hk_xtal_ena_i,
  input  logic                           hk_reg_ena_i,
  input  logic                           hk_pll_cp_ena_i,
  input  logic                           hk_pll_vco_ena_i,
  input  logic                           hk_pll_bias_ena_i,
  input  logic [io_pkg::HK_TRIM_W-1:0]   hk_pll_trim_i,
  input  logic [io_pkg::HK_MFGR_W-1:0]   hk_mfgr_id_i,
  input  logic [io_pkg::HK_PROD_W-1:0]   hk_prod_id_i,
  input  logic [io_pkg::HK_MASK_W-1:0]   hk_mask_rev_i,
  input  logic                           clk_ext_sel_i,
  output logic [io_pkg::DATA_W-1:0]      rdata_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_dat_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_oeb_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_pu_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_pd_o,
  output logic [io_pkg::SEL_W-1:0]       xtal_dest_o,
  output logic [io_pkg::SEL_W-1:0]       pll_dest_o,
  output logic [io_pkg::SEL_W-1:0]       trap_dest_o,
  output logic [io_pkg::SEL_W-1:0]       irq7_src_o,
  output logic [io_pkg::SEL_W-1:0]       irq8_src_o
);

  import io_pkg::*;

  logic [GPIO_W-1:0]               dat_q;
  logic [GPIO_W-1:0]               oeb_q;
  logic [GPIO_W-1:0]               pu_q;
  logic [GPIO_W-1:0]               pd_q;
  logic [SEL_W-1:0]                xtal_q;
  logic [SEL_W-1:0]                pll_q;
  logic [SEL_W-1:0]                trap_q;
  logic [SEL_W-1:0]                irq7_q;
  logic [SEL_W-1:0]                irq8_q;
  logic [DATA_W-1:0]               rd_word;
  logic [DATA_W-1:0]               rdata_q;
  logic                            wr;
  logic                            wr_known;
  logic [4*GPIO_W+5*SEL_W-1:0]     ctl_state;

  // byte lanes 0 and 1 of a 16-bit gpio register
  function automatic logic [GPIO_W-1:0] lane_merge(input logic [GPIO_W-1:0] old,
                                                   input logic [DATA_W-1:0] data,
                                                   input logic [STRB_W-1:0] strb);
    logic [GPIO_W-1:0] res;
    res = old;
    if (strb[0]) begin
      res[7:0] = data[7:0];
    end
    if (strb[1]) begin
      res[15:8] = data[15:8];
    end
    return res;
  endfunction

  assign wr = acc_i && (wstrb_i != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dat_q  <= '0;
      oeb_q  <= OEB_RESET;
      pu_q   <= '0;
      pd_q   <= '0;
      xtal_q <= '0;
      pll_q  <= '0;
      trap_q <= '0;
      irq7_q <= '0;
      irq8_q <= '0;
    end else if (wr) begin
      case (ofs_i)
        OFS_GPIO_DAT:  dat_q <= lane_merge(dat_q, wdata_i, wstrb_i);
        OFS_GPIO_OEB:  oeb_q <= lane_merge(oeb_q, wdata_i, wstrb_i);
        OFS_GPIO_PU:   pu_q  <= lane_merge(pu_q, wdata_i, wstrb_i);
        OFS_GPIO_PD:   pd_q  <= lane_merge(pd_q, wdata_i, wstrb_i);
        // route codes sit in lane 0 only
        OFS_XTAL_DEST: if (wstrb_i[0]) xtal_q <= wdata_i[SEL_W-1:0];
        OFS_PLL_DEST:  if (wstrb_i[0]) pll_q  <= wdata_i[SEL_W-1:0];
        OFS_TRAP_DEST: if (wstrb_i[0]) trap_q <= wdata_i[SEL_W-1:0];
        OFS_IRQ7_SRC:  if (wstrb_i[0]) irq7_q <= wdata_i[SEL_W-1:0];
        OFS_IRQ8_SRC:  if (wstrb_i[0]) irq8_q <= wdata_i[SEL_W-1:0];
        default: ;
      endcase
    end
  end

  // read word built from the contents before this access
  always_comb begin
    case (ofs_i)
      OFS_GPIO_DAT:  rd_word = {gpio_out_i, gpio_in_i};
      OFS_GPIO_OEB:  rd_word = DATA_W'(oeb_q);
      OFS_GPIO_PU:   rd_word = DATA_W'(pu_q);
      OFS_GPIO_PD:   rd_word = DATA_W'(pd_q);
      OFS_HK_CFG:    rd_word = DATA_W'(hk_config_i);
      OFS_HK_ENA:    rd_word = DATA_W'({hk_xtal_ena_i, hk_reg_ena_i});
      OFS_HK_PLL:    rd_word = DATA_W'({hk_pll_trim_i, hk_pll_cp_ena_i,
                                        hk_pll_vco_ena_i, hk_pll_bias_ena_i});
      OFS_HK_MFGR:   rd_word = DATA_W'(hk_mfgr_id_i);
      OFS_HK_PROD:   rd_word = DATA_W'(hk_prod_id_i);
      OFS_HK_MASK:   rd_word = DATA_W'(hk_mask_rev_i);
      OFS_CLK_SEL:   rd_word = DATA_W'(clk_ext_sel_i);
      OFS_XTAL_DEST: rd_word = DATA_W'(xtal_q);
      OFS_PLL_DEST:  rd_word = DATA_W'(pll_q);
      OFS_TRAP_DEST: rd_word = DATA_W'(trap_q);
      OFS_IRQ7_SRC:  rd_word = DATA_W'(irq7_q);
      OFS_IRQ8_SRC:  rd_word = DATA_W'(irq8_q);
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (acc_i) begin
      rdata_q <= rd_word;
    end
  end

  assign rdata_o     = rdata_q;
  assign gpio_dat_o  = dat_q;
  assign gpio_oeb_o  = oeb_q;
  assign gpio_pu_o   = pu_q;
  assign gpio_pd_o   = pd_q;
  assign xtal_dest_o = xtal_q;
  assign pll_dest_o  = pll_q;
  assign trap_dest_o = trap_q;
  assign irq7_src_o  = irq7_q;
  assign irq8_src_o  = irq8_q;

  assign wr_known = ofs_i inside {OFS_GPIO_DAT, OFS_GPIO_OEB, OFS_GPIO_PU, OFS_GPIO_PD,
                                  OFS_XTAL_DEST, OFS_PLL_DEST, OFS_TRAP_DEST,
                                  OFS_IRQ7_SRC, OFS_IRQ8_SRC};
  assign ctl_state = {dat_q, oeb_q, pu_q, pd_q, xtal_q, pll_q, trap_q, irq7_q, irq8_q};

  // writes to housekeeping or holes leave all control state alone
  wr_only_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr && !wr_known) |=> $stable(ctl_state));

endmodule

// ==== hdl/pin_route_mux.sv ====
`timescale 1ns/1ps

module pin_route_mux (
  input  logic                        rst_n_i,
  input  logic                        clk_i,
  input  logic                        xtal_in_i,
  input  logic                        clk_pll_i,
  input  logic                        trap_i,
  input  logic [io_pkg::GPIO_W-1:0]   gpio_in_i,
  input  logic [io_pkg::GPIO_W-1:0]   gpio_dat_i,
  input  logic [io_pkg::GPIO_W-1:0]   gpio_oeb_i,
  input  logic [io_pkg::GPIO_W-1:0]   gpio_pu_i,
  input  logic [io_pkg::GPIO_W-1:0]   gpio_pd_i,
  input  logic [io_pkg::SEL_W-1:0]    xtal_dest_i,
  input  logic [io_pkg::SEL_W-1:0]    pll_dest_i,
  input  logic [io_pkg::SEL_W-1:0]    trap_dest_i,
  input  logic [io_pkg::SEL_W-1:0]    irq7_src_i,
  input  logic [io_pkg::SEL_W-1:0]    irq8_src_i,
  output logic [io_pkg::GPIO_W-1:0]   gpio_out_o,
  output logic [io_pkg::GPIO_W-1:0]   gpio_outenb_o,
  output logic [io_pkg::GPIO_W-1:0]   gpio_pullupb_o,
  output logic [io_pkg::GPIO_W-1:0]   gpio_pulldownb_o,
  output logic                        irq7_o,
  output logic                        irq8_o
);

  import io_pkg::*;

  logic [GPIO_W-1:0] grp_en;
  logic [GPIO_W-1:0] pin_sel;
  logic [GPIO_W-1:0] pin_val;

  // one-hot pin of a three-pin group, code 0 picks none
  function automatic logic [2:0] pin_mask(input logic [SEL_W-1:0] code);
    case (code)
      2'd1:    return 3'b001;
      2'd2:    return 3'b010;
      2'd3:    return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  function automatic logic pick3(input logic [2:0] src, input logic [SEL_W-1:0] code);
    return |(src & pin_mask(code));
  endfunction

  always_comb begin
    grp_en  = '0;
    pin_sel = '0;
    pin_val = '0;

    grp_en[XTAL_PIN_LO +: 3]  = {3{xtal_dest_i != '0}};
    pin_sel[XTAL_PIN_LO +: 3] = pin_mask(xtal_dest_i);
    pin_val[XTAL_PIN_LO +: 3] = {3{xtal_in_i}};

    // pll group only drives its first two pins, code 3 just claims the group
    grp_en[PLL_PIN_LO +: 3]   = {3{pll_dest_i != '0}};
    pin_sel[PLL_PIN_LO +: 3]  = pin_mask(pll_dest_i) & 3'b011;
    pin_val[PLL_PIN_LO +: 3]  = {1'b0, clk_i, clk_pll_i};

    grp_en[TRAP_PIN_LO +: 3]  = {3{trap_dest_i != '0}};
    pin_sel[TRAP_PIN_LO +: 3] = pin_mask(trap_dest_i);
    pin_val[TRAP_PIN_LO +: 3] = {3{trap_i}};
  end

  assign gpio_out_o       = (gpio_dat_i & ~pin_sel) | (pin_val & pin_sel);
  // pads stay tristated while in reset
  assign gpio_outenb_o    = {GPIO_W{~rst_n_i}} | (gpio_oeb_i & ~grp_en);
  assign gpio_pullupb_o   = gpio_pu_i | grp_en;
  assign gpio_pulldownb_o = gpio_pd_i | grp_en;

  assign irq7_o = pick3(gpio_in_i[IRQ7_PIN_LO +: 3], irq7_src_i);
  assign irq8_o = pick3(gpio_in_i[IRQ8_PIN_LO +: 3], irq8_src_i);

endmodule

// ==== hdl/io_subsys_top.sv ====
`timescale 1ns/1ps

module io_subsys_top (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           bus_req_i,
  input  logic [io_pkg::ADDR_W-1:0]      bus_addr_i,
  input  logic [io_pkg::DATA_W-1:0]      bus_wdata_i,
  input  logic [io_pkg::STRB_W-1:0]      bus_wstrb_i,
  output logic                           bus_ack_o,
  output logic [io_pkg::DATA_W-1:0]      bus_rdata_o,
  input  logic                           xtal_in_i,
  input  logic                           clk_pll_i,
  input  logic                           trap_i,
  input  logic                           clk_ext_sel_i,
  input  logic [io_pkg::HK_CFG_W-1:0]    hk_config_i,
  input  logic                           hk_xtal_ena_i,
  input  logic                           hk_reg_ena_i,
  input  logic                           hk_pll_cp_ena_i,
  input  logic                           hk_pll_vco_ena_i,
  input  logic                           hk_pll_bias_ena_i,
  input  logic [io_pkg::HK_TRIM_W-1:0]   hk_pll_trim_i,
  input  logic [io_pkg::HK_MFGR_W-1:0]   hk_mfgr_id_i,
  input  logic [io_pkg::HK_PROD_W-1:0]   hk_prod_id_i,
  input  logic [io_pkg::HK_MASK_W-1:0]   hk_mask_rev_i,
  input  logic [io_pkg::GPIO_W-1:0]      gpio_in_i,
  output logic [io_pkg::GPIO_W-1:0]      gpio_out_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_outenb_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_pullupb_o,
  output logic [io_pkg::GPIO_W-1:0]      gpio_pulldownb_o,
  output logic                           irq7_o,
  output logic                           irq8_o
);

  import io_pkg::*;

  // bus slave to register block
  logic              acc;
  logic [7:0]        ofs;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic [DATA_W-1:0] rdata;

  // register values into the pad mux
  logic [GPIO_W-1:0] gpio_dat;
  logic [GPIO_W-1:0] gpio_oeb;
  logic [GPIO_W-1:0] gpio_pu;
  logic [GPIO_W-1:0] gpio_pd;
  logic [SEL_W-1:0]  xtal_dest;
  logic [SEL_W-1:0]  pll_dest;
  logic [SEL_W-1:0]  trap_dest;
  logic [SEL_W-1:0]  irq7_src;
  logic [SEL_W-1:0]  irq8_src;

  io_bus_slave u_bus_slave (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_wstrb_i (bus_wstrb_i),
    .bus_ack_o   (bus_ack_o),
    .bus_rdata_o (bus_rdata_o),
    .acc_o       (acc),
    .ofs_o       (ofs),
    .wdata_o     (wdata),
    .wstrb_o     (wstrb),
    .rdata_i     (rdata)
  );

  io_ctrl_regs u_ctrl_regs (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .acc_i             (acc),
    .ofs_i             (ofs),
    .wdata_i           (wdata),
    .wstrb_i           (wstrb),
    .gpio_in_i         (gpio_in_i),
    .gpio_out_i        (gpio_out_o),
    .hk_config_i       (hk_config_i),
    .hk_xtal_ena_i     (hk_xtal_ena_i),
    .hk_reg_ena_i      (hk_reg_ena_i),
    .hk_pll_cp_ena_i   (hk_pll_cp_ena_i),
    .hk_pll_vco_ena_i  (hk_pll_vco_ena_i),
    .hk_pll_bias_ena_i (hk_pll_bias_ena_i),
    .hk_pll_trim_i     (hk_pll_trim_i),
    .hk_mfgr_id_i      (hk_mfgr_id_i),
    .hk_prod_id_i      (hk_prod_id_i),
    .hk_mask_rev_i     (hk_mask_rev_i),
    .clk_ext_sel_i     (clk_ext_sel_i),
    .rdata_o           (rdata),
    .gpio_dat_o        (gpio_dat),
    .gpio_oeb_o        (gpio_oeb),
    .gpio_pu_o         (gpio_pu),
    .gpio_pd_o         (gpio_pd),
    .xtal_dest_o       (xtal_dest),
    .pll_dest_o        (pll_dest),
    .trap_dest_o       (trap_dest),
    .irq7_src_o        (irq7_src),
    .irq8_src_o        (irq8_src)
  );

  pin_route_mux u_route_mux (
    .rst_n_i          (rst_n_i),
    .clk_i            (clk_i),
    .xtal_in_i        (xtal_in_i),
    .clk_pll_i        (clk_pll_i),
    .trap_i           (trap_i),
    .gpio_in_i        (gpio_in_i),
    .gpio_dat_i       (gpio_dat),
    .gpio_oeb_i       (gpio_oeb),
    .gpio_pu_i        (gpio_pu),
    .gpio_pd_i        (gpio_pd),
    .xtal_dest_i      (xtal_dest),
    .pll_dest_i       (pll_dest),
    .trap_dest_i      (trap_dest),
    .irq7_src_i       (irq7_src),
    .irq8_src_i       (irq8_src),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq7_o           (irq7_o),
    .irq8_o           (irq8_o)
  );

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        bus_req_i,
  input  logic        bus_ack_i,
  input  logic [31:0] bus_rdata_i,
  input  logic [15:0] gpio_out_i,
  input  logic [15:0] gpio_outenb_i,
  input  logic [15:0] gpio_pullupb_i,
  input  logic [15:0] gpio_pulldownb_i,
  input  logic        irq7_i,
  input  logic        irq8_i,
  input  int          test_id_i,
  input  logic [31:0] exp_rdata_i,
  input  logic [15:0] exp_out_i,
  input  logic [15:0] exp_oeb_i,
  input  logic [15:0] exp_pu_i,
  input  logic [15:0] exp_pd_i,
  input  logic [1:0]  exp_irq_i,
  output int          checks_o,
  output int          fails_o,
  output int          misc_errs_o
);

  int   rst_cycles = 0;
  int   rst_errs = 0;
  logic rst_done = 1'b0;
  logic ack_prev = 1'b0;
  int   checks = 0;
  int   fails = 0;
  int   misc_errs = 0;

  function automatic int differs(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    if (exp !== got) begin
      $display("[ERROR] %s exp=%h got=%h", name, exp, got);
      return 1;
    end
    return 0;
  endfunction

  // everything sampled mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    int errs;
    errs = 0;
    if (!rst_n_i) begin
      rst_cycles++;
      // registers settle on the first reset edge
      if (rst_cycles > 1) begin
        errs += differs("bus_ack", 32'h0, 32'(bus_ack_i));
        errs += differs("gpio_outenb", 32'h0000ffff, 32'(gpio_outenb_i));
        errs += differs("gpio_out", 32'h0, 32'(gpio_out_i));
        errs += differs("gpio_pullupb", 32'h0, 32'(gpio_pullupb_i));
        errs += differs("gpio_pulldownb", 32'h0, 32'(gpio_pulldownb_i));
      end
      rst_errs += errs;
    end else begin
      if (!rst_done) begin
        rst_done = 1'b1;
        misc_errs += rst_errs;
        $display("reset check: %s", (rst_errs == 0) ? "ok" : "failed");
      end
      // handshake ordering
      if (bus_ack_i && !ack_prev && !bus_req_i) begin
        $display("ack rose with no request pending in test %0h", test_id_i);
        misc_errs++;
      end
      if (!bus_ack_i && ack_prev && bus_req_i) begin
        $display("ack dropped while the request of test %0h was still held", test_id_i);
        misc_errs++;
      end
      if (bus_ack_i && !ack_prev) begin
        errs += differs("bus_rdata", exp_rdata_i, bus_rdata_i);
        errs += differs("gpio_out", 32'(exp_out_i), 32'(gpio_out_i));
        errs += differs("gpio_outenb", 32'(exp_oeb_i), 32'(gpio_outenb_i));
        errs += differs("gpio_pullupb", 32'(exp_pu_i), 32'(gpio_pullupb_i));
        errs += differs("gpio_pulldownb", 32'(exp_pd_i), 32'(gpio_pulldownb_i));
        errs += differs("irq8_irq7", 32'(exp_irq_i), 32'({irq8_i, irq7_i}));
        checks++;
        if (errs == 0) begin
          $display("test %0h: ok", test_id_i);
        end else begin
          fails++;
          $display("test %0h: failed with %0d mismatches", test_id_i, errs);
        end
      end
      ack_prev = bus_ack_i;
    end
  end

  assign checks_o    = checks;
  assign fails_o     = fails;
  assign misc_errs_o = misc_errs;

endmodule

// ==== test/tb_io_subsys.sv ====
`timescale 1ns/1ps

module tb_io_subsys;

  import io_pkg::*;

  // one pattern line holds this many hex words
  localparam int FIELDS          = 14;
  localparam int MEM_AW          = 10;
  localparam int MAX_TESTS       = 64;
  localparam int RESET_CYCLES    = 16;
  localparam int CYCLES_PER_TEST = 40;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic                 bus_req = 1'b0;
  logic [ADDR_W-1:0]    bus_addr = '0;
  logic [DATA_W-1:0]    bus_wdata = '0;
  logic [STRB_W-1:0]    bus_wstrb = '0;
  logic                 xtal_in = 1'b0;
  logic                 clk_pll = 1'b0;
  logic                 trap = 1'b0;
  logic                 clk_ext_sel = 1'b0;
  logic [HK_CFG_W-1:0]  hk_config = '0;
  logic                 hk_xtal_ena = 1'b0;
  logic                 hk_reg_ena = 1'b0;
  logic                 hk_pll_cp_ena = 1'b0;
  logic                 hk_pll_vco_ena = 1'b0;
  logic                 hk_pll_bias_ena = 1'b0;
  logic [HK_TRIM_W-1:0] hk_pll_trim = '0;
  logic [HK_MFGR_W-1:0] hk_mfgr_id = '0;
  logic [HK_PROD_W-1:0] hk_prod_id = '0;
  logic [HK_MASK_W-1:0] hk_mask_rev = '0;
  logic [GPIO_W-1:0]    gpio_in = '0;

  logic                 bus_ack;
  logic [DATA_W-1:0]    bus_rdata;
  logic [GPIO_W-1:0]    gpio_out;
  logic [GPIO_W-1:0]    gpio_outenb;
  logic [GPIO_W-1:0]    gpio_pullupb;
  logic [GPIO_W-1:0]    gpio_pulldownb;
  logic                 irq7;
  logic                 irq8;

  // expected values of the access in flight
  int                   test_id = 0;
  logic [DATA_W-1:0]    exp_rdata = '0;
  logic [GPIO_W-1:0]    exp_out = '0;
  logic [GPIO_W-1:0]    exp_oeb = '0;
  logic [GPIO_W-1:0]    exp_pu = '0;
  logic [GPIO_W-1:0]    exp_pd = '0;
  logic [1:0]           exp_irq = '0;

  logic [31:0]          pat_mem [0:(1<<MEM_AW)-1];
  int                   num_tests = 0;
  int                   cycles = 0;
  int                   limit = RESET_CYCLES + CYCLES_PER_TEST * MAX_TESTS;
  int                   checks;
  int                   fails;
  int                   misc_errs;

  always #2 clk = ~clk;

  io_subsys_top io_subsys_top_inst (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .bus_req_i         (bus_req),
    .bus_addr_i        (bus_addr),
    .bus_wdata_i       (bus_wdata),
    .bus_wstrb_i       (bus_wstrb),
    .bus_ack_o         (bus_ack),
    .bus_rdata_o       (bus_rdata),
    .xtal_in_i         (xtal_in),
    .clk_pll_i         (clk_pll),
    .trap_i            (trap),
    .clk_ext_sel_i     (clk_ext_sel),
    .hk_config_i       (hk_config),
    .hk_xtal_ena_i     (hk_xtal_ena),
    .hk_reg_ena_i      (hk_reg_ena),
    .hk_pll_cp_ena_i   (hk_pll_cp_ena),
    .hk_pll_vco_ena_i  (hk_pll_vco_ena),
    .hk_pll_bias_ena_i (hk_pll_bias_ena),
    .hk_pll_trim_i     (hk_pll_trim),
    .hk_mfgr_id_i      (hk_mfgr_id),
    .hk_prod_id_i      (hk_prod_id),
    .hk_mask_rev_i     (hk_mask_rev),
    .gpio_in_i         (gpio_in),
    .gpio_out_o        (gpio_out),
    .gpio_outenb_o     (gpio_outenb),
    .gpio_pullupb_o    (gpio_pullupb),
    .gpio_pulldownb_o  (gpio_pulldownb),
    .irq7_o            (irq7),
    .irq8_o            (irq8)
  );

  tb_checker chk (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .bus_req_i        (bus_req),
    .bus_ack_i        (bus_ack),
    .bus_rdata_i      (bus_rdata),
    .gpio_out_i       (gpio_out),
    .gpio_outenb_i    (gpio_outenb),
    .gpio_pullupb_i   (gpio_pullupb),
    .gpio_pulldownb_i (gpio_pulldownb),
    .irq7_i           (irq7),
    .irq8_i           (irq8),
    .test_id_i        (test_id),
    .exp_rdata_i      (exp_rdata),
    .exp_out_i        (exp_out),
    .exp_oeb_i        (exp_oeb),
    .exp_pu_i         (exp_pu),
    .exp_pd_i         (exp_pd),
    .exp_irq_i        (exp_irq),
    .checks_o         (checks),
    .fails_o          (fails),
    .misc_errs_o      (misc_errs)
  );

  function automatic logic [31:0] pat_word(input int test, input int field);
    logic [MEM_AW-1:0] addr;
    addr = MEM_AW'(test * FIELDS + field);
    return pat_mem[addr];
  endfunction

  // one four-phase access, inputs and expectations settle a cycle ahead
  task automatic run_test(input int idx);
    logic [31:0] src;
    logic [31:0] hk_a;
    logic [31:0] hk_b;
    int          extra;
    src   = pat_word(idx, 5);
    hk_a  = pat_word(idx, 6);
    hk_b  = pat_word(idx, 7);
    extra = idx % 3;
    @(posedge clk);
    test_id   <= int'(pat_word(idx, 0));
    gpio_in   <= GPIO_W'(pat_word(idx, 4));
    xtal_in   <= src[2];
    clk_pll   <= src[1];
    trap      <= src[0];
    {hk_mfgr_id, hk_prod_id, hk_config, hk_pll_trim} <= hk_a;
    hk_mask_rev     <= hk_b[11:8];
    clk_ext_sel     <= hk_b[5];
    hk_xtal_ena     <= hk_b[4];
    hk_reg_ena      <= hk_b[3];
    hk_pll_cp_ena   <= hk_b[2];
    hk_pll_vco_ena  <= hk_b[1];
    hk_pll_bias_ena <= hk_b[0];
    exp_rdata <= pat_word(idx, 8);
    exp_out   <= GPIO_W'(pat_word(idx, 9));
    exp_oeb   <= GPIO_W'(pat_word(idx, 10));
    exp_pu    <= GPIO_W'(pat_word(idx, 11));
    exp_pd    <= GPIO_W'(pat_word(idx, 12));
    exp_irq   <= 2'(pat_word(idx, 13));
    @(posedge clk);
    bus_addr  <= pat_word(idx, 1);
    bus_wdata <= pat_word(idx, 2);
    bus_wstrb <= STRB_W'(pat_word(idx, 3));
    bus_req   <= 1'b1;
    @(negedge clk);
    while (!bus_ack) begin
      @(negedge clk);
    end
    // hold req a little longer on some tests
    repeat (extra) @(posedge clk);
    @(posedge clk);
    bus_req <= 1'b0;
    @(negedge clk);
    while (bus_ack) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    int          i;
    logic [31:0] last_id;
    last_id = '0;
    $readmemh("test/io_patterns.mem", pat_mem);
    // hex ids climb line by line, the first empty slot ends the list
    while (num_tests < MAX_TESTS && pat_word(num_tests, 0) > last_id) begin
      last_id = pat_word(num_tests, 0);
      num_tests++;
    end
    limit = RESET_CYCLES + CYCLES_PER_TEST * num_tests;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (i = 0; i < num_tests; i++) begin
      run_test(i);
    end
    repeat (2) @(posedge clk);
    $display("tests %0d, checked %0d, failed %0d, other errors %0d",
             num_tests, checks, fails, misc_errs);
    if (num_tests > 0 && checks == num_tests && fails == 0 && misc_errs == 0) begin
      $display("** PASS **");
    end else begin
      if (num_tests == 0) begin
        $display("no test patterns could be read");
      end else if (checks != num_tests) begin
        $display("only %0d of %0d accesses were checked", checks, num_tests);
      end
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== test/io_patterns.mem ====
// id addr wdata strb gpio_in src{xtal,pll,trap} hk_a{mfgr,prod,cfg,trim}
// hk_b{mask[11:8],clk_sel[5],xtal,reg,cp,vco,bias} rdata out outenb pullupb pulldownb irq{8,7}
01 03000004 00000000 0 0000 0 4563ca59 00000735 0000ffff 0000 ffff 0000 0000 0
02 03000000 00000000 0 1234 0 4563ca59 00000735 00001234 0000 ffff 0000 0000 0
03 03000000 0000a55a 3 0000 0 4563ca59 00000735 00000000 a55a ffff 0000 0000 0
04 03000000 00003cff 2 0000 0 4563ca59 00000735 a55a0000 3c5a ffff 0000 0000 0
05 03000000 00000000 0 00f0 0 4563ca59 00000735 3c5a00f0 3c5a ffff 0000 0000 0
06 03000004 000000ef 1 0000 0 4563ca59 00000735 0000ffff 3c5a ffef 0000 0000 0
07 03000004 0000c3ff 2 0000 0 4563ca59 00000735 0000ffef 3c5a c3ef 0000 0000 0
08 03000004 00000000 0 0000 0 4563ca59 00000735 0000c3ef 3c5a c3ef 0000 0000 0
09 03000008 12345678 f 0000 0 4563ca59 00000735 00000000 3c5a c3ef 5678 0000 0
10 0300000c 0000abcd 1 0000 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 0
11 0300000c 00000000 0 0000 0 4563ca59 00000735 000000cd 3c5a c3ef 5678 00cd 0
12 03000008 00000000 0 0000 0 4563ca59 00000735 00005678 3c5a c3ef 5678 00cd 0
// pad routing groups
13 030000a0 00000002 1 0000 0 4563ca59 00000735 00000000 3c1a c30f 56f8 00ed 0
14 03000000 00000000 0 0000 4 4563ca59 00000735 3c5a0000 3c5a c30f 56f8 00ed 0
15 030000a0 00000000 1 0000 4 4563ca59 00000735 00000002 3c5a c3ef 5678 00cd 0
16 030000a4 00000001 1 0000 2 4563ca59 00000735 00000000 3d5a c0ef 5778 07cd 0
17 030000a4 00000003 1 0000 2 4563ca59 00000735 00000001 3c5a c0ef 5778 07cd 0
18 030000a4 00000000 1 0000 0 4563ca59 00000735 00000003 3c5a c3ef 5678 00cd 0
19 030000a8 00000003 1 0000 0 4563ca59 00000735 00000000 1c5a c3ef 7e78 38cd 0
20 03000000 00000000 0 0000 1 4563ca59 00000735 3c5a0000 3c5a c3ef 7e78 38cd 0
21 030000a8 00000000 1 0000 1 4563ca59 00000735 00000003 3c5a c3ef 5678 00cd 0
// interrupt source selectors
22 030000b0 00000002 1 0002 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 1
23 030000b4 00000003 1 0022 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 3
24 030000b0 00000000 0 0020 0 4563ca59 00000735 00000002 3c5a c3ef 5678 00cd 2
25 030000b0 00000000 1 0022 0 4563ca59 00000735 00000002 3c5a c3ef 5678 00cd 2
26 030000b4 00000000 0 0000 0 4563ca59 00000735 00000003 3c5a c3ef 5678 00cd 0
// housekeeping, holes and foreign pages
27 03000080 00000000 0 0000 0 4563ca59 00000735 000000a5 3c5a c3ef 5678 00cd 0
28 03000088 00000000 0 0000 0 4563ca59 00000735 0000004d 3c5a c3ef 5678 00cd 0
29 03000084 ffffffff f 0000 0 4563ca59 00000735 00000002 3c5a c3ef 5678 00cd 0
30 03000090 00000000 0 0000 0 4563ca59 00000735 0000003c 3c5a c3ef 5678 00cd 0
31 03000094 00000000 0 0000 0 4563ca59 00000735 00000007 3c5a c3ef 5678 00cd 0
32 03000098 00000000 0 0000 0 4563ca59 00000735 00000001 3c5a c3ef 5678 00cd 0
33 0300008c 00000000 0 0000 0 abc5a3c6 0000001a 00000abc 3c5a c3ef 5678 00cd 0
34 03000088 00000000 0 0000 0 abc5a3c6 0000001a 00000032 3c5a c3ef 5678 00cd 0
35 03000084 00000000 0 0000 0 abc5a3c6 0000001a 00000003 3c5a c3ef 5678 00cd 0
36 0300005c 00000000 0 0000 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 0
37 03000010 ffffffff f 0000 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 0
38 04000004 00000000 0 0000 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 0
39 03000104 00000000 f 0000 0 4563ca59 00000735 00000000 3c5a c3ef 5678 00cd 0
40 03000004 00000000 0 0000 0 4563ca59 00000735 0000c3ef 3c5a c3ef 5678 00cd 0
41 03000000 00000000 0 5a5a 0 4563ca59 00000735 3c5a5a5a 3c5a c3ef 5678 00cd 0

// ==== flist.f ====
hdl/io_pkg.sv
hdl/io_bus_slave.sv
hdl/io_ctrl_regs.sv
hdl/pin_route_mux.sv
hdl/io_subsys_top.sv
test/tb_checker.sv
test/tb_io_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_io_subsys \
  --Mdir obj_dir -o tb_io_subsys
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_io_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  exit 0
fi

echo "pass message not found in $LOG"
exit 1
